/* exec_unit.f */
+incdir+include
hw/exec_pkg.sv
hw/div_if.sv
hw/exec_alu.sv
hw/exec_divider.sv
hw/exec_pipe_reg.sv
hw/exec_ctrl.sv
hw/exec_stage.sv
test/tb_exec_stage.sv

/* Bender.yml */
package:
  name: exec_unit

sources:
  - include_dirs:
      - include
    files:
      - hw/exec_pkg.sv
      - hw/div_if.sv
      - hw/exec_alu.sv
      - hw/exec_divider.sv
      - hw/exec_pipe_reg.sv
      - hw/exec_ctrl.sv
      - hw/exec_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_exec_stage.sv

/* test/tb_exec_stage.sv */
`default_nettype none
`include "exec_config.svh"

module tb_exec_stage;

    typedef logic [`EXEC_XLEN-1:0] word_t;

    localparam word_t MIN_NEG = {1'b1, {(`EXEC_XLEN-1){1'b0}}};
    localparam int DIV_RUNS = 4 * 6 + 2;
    localparam int WATCHDOG_CYCLES = 16 + 600 + DIV_RUNS * (`EXEC_DIV_STEPS + 16);

    logic              clk = 1'b0;
    logic              rst_n;
    logic              flush;
    logic              mem_stall;
    word_t             in_pc;
    word_t             in_op1;
    word_t             in_op2;
    word_t             in_rs2;
    word_t             in_imm_b;
    exec_pkg::alu_op_e in_op;
    logic              in_rf_wen;
    logic [4:0]        in_wb_addr;
    logic              ex_stall;
    word_t             alu_out;
    logic              br_taken;
    word_t             br_target;
    word_t             out_pc;
    word_t             out_rs2;
    logic              out_rf_wen;
    logic [4:0]        out_wb_addr;

    int          errors;
    int          checks;
    logic [31:0] lfsr;

    exec_stage i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .mem_stall   (mem_stall),
        .in_pc       (in_pc),
        .in_op1      (in_op1),
        .in_op2      (in_op2),
        .in_rs2      (in_rs2),
        .in_imm_b    (in_imm_b),
        .in_op       (in_op),
        .in_rf_wen   (in_rf_wen),
        .in_wb_addr  (in_wb_addr),
        .ex_stall    (ex_stall),
        .alu_out     (alu_out),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .out_pc      (out_pc),
        .out_rs2     (out_rs2),
        .out_rf_wen  (out_rf_wen),
        .out_wb_addr (out_wb_addr)
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[`EXEC_XLEN-2:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic word_t alu_model(input exec_pkg::alu_op_e op, input word_t a, input word_t b);
        case (op)
            exec_pkg::ALU_ADD:   return a + b;
            exec_pkg::ALU_SUB:   return a - b;
            exec_pkg::ALU_AND:   return a & b;
            exec_pkg::ALU_OR:    return a | b;
            exec_pkg::ALU_XOR:   return a ^ b;
            exec_pkg::ALU_SLL:   return a << b[4:0];
            exec_pkg::ALU_SRL:   return a >> b[4:0];
            exec_pkg::ALU_SRA:   return $signed(a) >>> b[4:0];
            exec_pkg::ALU_SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
            exec_pkg::ALU_SLTU:  return (a < b) ? 1 : 0;
            exec_pkg::ALU_JALR:  return (a + b) & ~word_t'(1);
            exec_pkg::ALU_COPY1: return a;
            default:             return '0;
        endcase
    endfunction

    function automatic logic branch_model(input exec_pkg::alu_op_e op, input word_t a, input word_t b);
        case (op)
            exec_pkg::BR_BEQ:  return a == b;
            exec_pkg::BR_BNE:  return a != b;
            exec_pkg::BR_BLT:  return $signed(a) < $signed(b);
            exec_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            exec_pkg::BR_BLTU: return a < b;
            exec_pkg::BR_BGEU: return a >= b;
            default:           return 1'b0;
        endcase
    endfunction

    function automatic word_t div_model(input exec_pkg::alu_op_e op, input word_t a, input word_t b);
        logic  sgn;
        logic  rem;
        word_t q;
        word_t r;
        sgn = (op == exec_pkg::ALU_DIV) || (op == exec_pkg::ALU_REM);
        rem = (op == exec_pkg::ALU_REM) || (op == exec_pkg::ALU_REMU);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == MIN_NEG && b == '1) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return rem ? r : q;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic drive_op(input exec_pkg::alu_op_e op, input word_t a, input word_t b,
                            input word_t pc, input word_t imm, input word_t rs2,
                            input logic wen, input logic [4:0] wa);
        in_op      <= op;
        in_op1     <= a;
        in_op2     <= b;
        in_pc      <= pc;
        in_imm_b   <= imm;
        in_rs2     <= rs2;
        in_rf_wen  <= wen;
        in_wb_addr <= wa;
    endtask

    task automatic drive_idle();
        in_op     <= exec_pkg::ALU_X;
        in_rf_wen <= 1'b0;
    endtask

    task automatic check_reset();
        @(negedge clk);
        check_word("out_rf_wen", out_rf_wen, 1'b0);
        check_word("br_taken", br_taken, 1'b0);
        check_word("ex_stall", ex_stall, 1'b0);
        check_word("out_pc", out_pc, `EXEC_PC_NOP);
    endtask

    task automatic run_alu_ops();
        exec_pkg::alu_op_e ops [12];
        word_t             a;
        word_t             b;
        word_t             pc;
        word_t             imm;
        word_t             rs2;
        logic [4:0]        wa;
        ops = '{exec_pkg::ALU_ADD, exec_pkg::ALU_SUB, exec_pkg::ALU_AND, exec_pkg::ALU_OR,
                exec_pkg::ALU_XOR, exec_pkg::ALU_SLL, exec_pkg::ALU_SRL, exec_pkg::ALU_SRA,
                exec_pkg::ALU_SLT, exec_pkg::ALU_SLTU, exec_pkg::ALU_JALR, exec_pkg::ALU_COPY1};
        foreach (ops[i]) begin
            for (int k = 0; k < 4; k++) begin
                a   = rand_bits(`EXEC_XLEN);
                b   = rand_bits(`EXEC_XLEN);
                pc  = rand_bits(`EXEC_XLEN);
                imm = rand_bits(`EXEC_XLEN);
                rs2 = rand_bits(`EXEC_XLEN);
                wa  = 5'(rand_bits(5));
                @(posedge clk);
                drive_op(ops[i], a, b, pc, imm, rs2, 1'b1, wa);
                @(posedge clk);
                drive_idle();
                @(negedge clk);
                check_word("alu_out", alu_out, alu_model(ops[i], a, b));
                check_word("out_pc", out_pc, pc);
                check_word("out_rs2", out_rs2, rs2);
                check_word("out_rf_wen", out_rf_wen, 1'b1);
                check_word("out_wb_addr", out_wb_addr, wa);
                check_word("br_taken", br_taken, 1'b0);
                check_word("br_target", br_target, pc + imm);
            end
        end
    endtask

    task automatic run_branches();
        exec_pkg::alu_op_e ops [6];
        word_t             pa [3];
        word_t             pb [3];
        word_t             x;
        word_t             pc;
        word_t             imm;
        ops = '{exec_pkg::BR_BEQ, exec_pkg::BR_BNE, exec_pkg::BR_BLT,
                exec_pkg::BR_BGE, exec_pkg::BR_BLTU, exec_pkg::BR_BGEU};
        x     = rand_bits(`EXEC_XLEN);
        pa[0] = x;
        pb[0] = x;
        // negative against positive, signed and unsigned order disagree
        pa[1] = rand_bits(`EXEC_XLEN) | MIN_NEG;
        pb[1] = rand_bits(`EXEC_XLEN) & ~MIN_NEG;
        x     = rand_bits(`EXEC_XLEN - 2);
        pa[2] = x;
        pb[2] = x + (word_t'(1) << (`EXEC_XLEN - 2));
        foreach (ops[i]) begin
            for (int p = 0; p < 3; p++) begin
                pc  = rand_bits(`EXEC_XLEN);
                imm = rand_bits(`EXEC_XLEN);
                @(posedge clk);
                drive_op(ops[i], pa[p], pb[p], pc, imm, '0, 1'b0, 5'd0);
                @(posedge clk);
                drive_idle();
                @(negedge clk);
                check_word("br_taken", br_taken, branch_model(ops[i], pa[p], pb[p]));
                check_word("br_target", br_target, pc + imm);
                check_word("out_rf_wen", out_rf_wen, 1'b0);
            end
        end
    endtask

    task automatic divide_once(input exec_pkg::alu_op_e op, input word_t a, input word_t b);
        word_t exp;
        int    waited;
        exp    = div_model(op, a, b);
        waited = 0;
        @(posedge clk);
        drive_op(op, a, b, rand_bits(`EXEC_XLEN), '0, '0, 1'b1, 5'd9);
        @(negedge clk);
        if (!ex_stall) begin
            errors++;
            $display("ex_stall did not rise for a divide operation");
        end
        while (ex_stall && waited <= `EXEC_DIV_STEPS + 8) begin
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            waited++;
            check_word("out_rf_wen", out_rf_wen, 1'b0);
        end
        if (ex_stall) begin
            errors++;
            $display("divide still stalling after %0d cycles", waited);
        end
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_word("alu_out", alu_out, exp);
        check_word("out_rf_wen", out_rf_wen, 1'b1);
    endtask

    task automatic run_divides();
        exec_pkg::alu_op_e ops [4];
        word_t             a;
        word_t             b;
        ops = '{exec_pkg::ALU_DIV, exec_pkg::ALU_DIVU, exec_pkg::ALU_REM, exec_pkg::ALU_REMU};
        foreach (ops[i]) begin
            for (int k = 0; k < 4; k++) begin
                a = rand_bits(`EXEC_XLEN);
                b = (k == 1) ? -rand_bits(16) : rand_bits(8 * (k + 1));
                divide_once(ops[i], a, b);
            end
            divide_once(ops[i], rand_bits(`EXEC_XLEN), '0);
            divide_once(ops[i], MIN_NEG, '1);
        end
    endtask

    task automatic run_mem_stall();
        word_t a;
        word_t b;
        word_t pc;
        word_t held_out;
        word_t held_pc;
        word_t exp;
        int    waited;
        a  = rand_bits(`EXEC_XLEN);
        b  = rand_bits(`EXEC_XLEN);
        pc = rand_bits(`EXEC_XLEN);
        @(posedge clk);
        drive_op(exec_pkg::ALU_XOR, a, b, pc, '0, '0, 1'b1, 5'd3);
        exp = alu_model(exec_pkg::ALU_XOR, a, b);
        a   = rand_bits(`EXEC_XLEN);
        b   = rand_bits(`EXEC_XLEN);
        pc  = rand_bits(`EXEC_XLEN);
        @(posedge clk);
        drive_op(exec_pkg::ALU_SUB, a, b, pc, '0, '0, 1'b1, 5'd4);
        mem_stall <= 1'b1;
        @(negedge clk);
        check_word("alu_out", alu_out, exp);
        held_out = alu_out;
        held_pc  = out_pc;
        repeat (4) begin
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            check_word("alu_out", alu_out, held_out);
            check_word("out_pc", out_pc, held_pc);
        end
        @(posedge clk);
        mem_stall <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_word("alu_out", alu_out, alu_model(exec_pkg::ALU_SUB, a, b));
        check_word("out_pc", out_pc, pc);
        check_word("out_wb_addr", out_wb_addr, 5'd4);

        // divide that completes while the memory stage is stalled
        a   = rand_bits(`EXEC_XLEN);
        b   = rand_bits(12);
        exp = div_model(exec_pkg::ALU_REM, a, b);
        @(posedge clk);
        drive_op(exec_pkg::ALU_REM, a, b, pc, '0, '0, 1'b1, 5'd5);
        repeat (3) begin
            @(posedge clk);
            drive_idle();
        end
        @(posedge clk);
        mem_stall <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (ex_stall && waited <= `EXEC_DIV_STEPS + 8) begin
            @(negedge clk);
            waited++;
        end
        if (ex_stall) begin
            errors++;
            $display("divide under memory stall still stalling after %0d cycles", waited);
        end
        // result stays parked for a few more stalled cycles
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_word("ex_stall", ex_stall, 1'b0);
        check_word("out_rf_wen", out_rf_wen, 1'b0);
        @(posedge clk);
        mem_stall <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_word("alu_out", alu_out, exp);
        check_word("out_rf_wen", out_rf_wen, 1'b1);
    endtask

    task automatic run_flush();
        word_t a;
        word_t b;
        a = rand_bits(`EXEC_XLEN);
        @(posedge clk);
        drive_op(exec_pkg::BR_BEQ, a, a, rand_bits(`EXEC_XLEN), rand_bits(`EXEC_XLEN),
                 '0, 1'b1, 5'd6);
        flush <= 1'b1;
        @(posedge clk);
        drive_idle();
        flush <= 1'b0;
        @(negedge clk);
        check_word("out_rf_wen", out_rf_wen, 1'b0);
        check_word("br_taken", br_taken, 1'b0);
        check_word("out_pc", out_pc, `EXEC_PC_NOP);

        // kill a divide halfway, then an add must go straight through
        @(posedge clk);
        drive_op(exec_pkg::ALU_DIVU, rand_bits(`EXEC_XLEN), rand_bits(16), '0, '0, '0,
                 1'b1, 5'd7);
        repeat (5) begin
            @(posedge clk);
            drive_idle();
        end
        @(posedge clk);
        flush <= 1'b1;
        a = rand_bits(`EXEC_XLEN);
        b = rand_bits(`EXEC_XLEN);
        @(posedge clk);
        flush <= 1'b0;
        drive_op(exec_pkg::ALU_ADD, a, b, '0, '0, '0, 1'b1, 5'd8);
        @(negedge clk);
        check_word("ex_stall", ex_stall, 1'b0);
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_word("alu_out", alu_out, alu_model(exec_pkg::ALU_ADD, a, b));
        check_word("out_rf_wen", out_rf_wen, 1'b1);
        check_word("out_wb_addr", out_wb_addr, 5'd8);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("timeout after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        flush      = 1'b0;
        mem_stall  = 1'b0;
        in_pc      = '0;
        in_op1     = '0;
        in_op2     = '0;
        in_rs2     = '0;
        in_imm_b   = '0;
        in_op      = exec_pkg::ALU_X;
        in_rf_wen  = 1'b0;
        in_wb_addr = '0;
        errors     = 0;
        checks     = 0;
        lfsr       = 32'hd7b0b610;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        check_reset();
        run_alu_ops();
        run_branches();
        run_divides();
        run_mem_stall();
        run_flush();
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`default_nettype none
`include "exec_config.svh"

module exec_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  mem_stall,
    input  logic [`EXEC_XLEN-1:0] in_pc,
    input  logic [`EXEC_XLEN-1:0] in_op1,
    input  logic [`EXEC_XLEN-1:0] in_op2,
    input  logic [`EXEC_XLEN-1:0] in_rs2,
    input  logic [`EXEC_XLEN-1:0] in_imm_b,
    input  exec_pkg::alu_op_e     in_op,
    input  logic                  in_rf_wen,
    input  logic [4:0]            in_wb_addr,
    output logic                  ex_stall,
    output logic [`EXEC_XLEN-1:0] alu_out,
    output logic                  br_taken,
    output logic [`EXEC_XLEN-1:0] br_target,
    output logic [`EXEC_XLEN-1:0] out_pc,
    output logic [`EXEC_XLEN-1:0] out_rs2,
    output logic                  out_rf_wen,
    output logic [4:0]            out_wb_addr
);

    exec_pkg::alu_op_e     cur_op;
    logic [`EXEC_XLEN-1:0] cur_op1;
    logic [`EXEC_XLEN-1:0] cur_op2;
    logic [`EXEC_XLEN-1:0] cur_pc;
    logic [`EXEC_XLEN-1:0] cur_imm_b;
    logic [`EXEC_XLEN-1:0] cur_rs2;
    logic                  cur_rf_wen;
    logic [4:0]            cur_wb_addr;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] result;
    logic                  alu_br_taken;
    logic [`EXEC_XLEN-1:0] alu_br_target;

    div_if i_div_if ();

    exec_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .mem_stall   (mem_stall),
        .in_pc       (in_pc),
        .in_op1      (in_op1),
        .in_op2      (in_op2),
        .in_rs2      (in_rs2),
        .in_imm_b    (in_imm_b),
        .in_op       (in_op),
        .in_rf_wen   (in_rf_wen),
        .in_wb_addr  (in_wb_addr),
        .dv          (i_div_if.ctrl),
        .cur_op      (cur_op),
        .cur_op1     (cur_op1),
        .cur_op2     (cur_op2),
        .cur_pc      (cur_pc),
        .cur_imm_b   (cur_imm_b),
        .alu_result  (alu_result),
        .result      (result),
        .ex_stall    (ex_stall),
        .cur_rs2     (cur_rs2),
        .cur_rf_wen  (cur_rf_wen),
        .cur_wb_addr (cur_wb_addr)
    );

    exec_alu i_alu (
        .op        (cur_op),
        .op1       (cur_op1),
        .op2       (cur_op2),
        .pc        (cur_pc),
        .imm_b     (cur_imm_b),
        .result    (alu_result),
        .br_taken  (alu_br_taken),
        .br_target (alu_br_target)
    );

    exec_divider i_divider (
        .clk   (clk),
        .rst_n (rst_n),
        .dv    (i_div_if.div)
    );

    exec_pipe_reg i_pipe_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .mem_stall     (mem_stall),
        .ex_stall      (ex_stall),
        .result        (result),
        .br_taken      (alu_br_taken),
        .br_target     (alu_br_target),
        .pc            (cur_pc),
        .rs2           (cur_rs2),
        .rf_wen        (cur_rf_wen),
        .wb_addr       (cur_wb_addr),
        .alu_out       (alu_out),
        .out_br_taken  (br_taken),
        .out_br_target (br_target),
        .out_pc        (out_pc),
        .out_rs2       (out_rs2),
        .out_rf_wen    (out_rf_wen),
        .out_wb_addr   (out_wb_addr)
    );

endmodule

`default_nettype wire

/* hw/exec_ctrl.sv */
`default_nettype none
`include "exec_config.svh"

module exec_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  mem_stall,
    input  logic [`EXEC_XLEN-1:0] in_pc,
    input  logic [`EXEC_XLEN-1:0] in_op1,
    input  logic [`EXEC_XLEN-1:0] in_op2,
    input  logic [`EXEC_XLEN-1:0] in_rs2,
    input  logic [`EXEC_XLEN-1:0] in_imm_b,
    input  exec_pkg::alu_op_e     in_op,
    input  logic                  in_rf_wen,
    input  logic [4:0]            in_wb_addr,
    div_if.ctrl                   dv,
    output exec_pkg::alu_op_e     cur_op,
    output logic [`EXEC_XLEN-1:0] cur_op1,
    output logic [`EXEC_XLEN-1:0] cur_op2,
    output logic [`EXEC_XLEN-1:0] cur_pc,
    output logic [`EXEC_XLEN-1:0] cur_imm_b,
    input  logic [`EXEC_XLEN-1:0] alu_result,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  ex_stall,
    output logic [`EXEC_XLEN-1:0] cur_rs2,
    output logic                  cur_rf_wen,
    output logic [4:0]            cur_wb_addr
);

    logic                  hold_q;
    exec_pkg::alu_op_e     sv_op;
    logic [`EXEC_XLEN-1:0] sv_op1;
    logic [`EXEC_XLEN-1:0] sv_op2;
    logic [`EXEC_XLEN-1:0] sv_pc;
    logic [`EXEC_XLEN-1:0] sv_imm_b;
    logic [`EXEC_XLEN-1:0] sv_rs2;
    logic                  sv_rf_wen;
    logic [4:0]            sv_wb_addr;

    exec_pkg::div_state_e  state_q;
    logic [`EXEC_XLEN-1:0] saved_q;
    logic [`EXEC_XLEN-1:0] div_pick;
    logic                  is_div;
    logic                  is_rem;
    logic                  div_ready;

    // replay the latched op for one cycle after any stall
    assign cur_op      = hold_q ? sv_op      : in_op;
    assign cur_op1     = hold_q ? sv_op1     : in_op1;
    assign cur_op2     = hold_q ? sv_op2     : in_op2;
    assign cur_pc      = hold_q ? sv_pc      : in_pc;
    assign cur_imm_b   = hold_q ? sv_imm_b   : in_imm_b;
    assign cur_rs2     = hold_q ? sv_rs2     : in_rs2;
    assign cur_rf_wen  = hold_q ? sv_rf_wen  : in_rf_wen;
    assign cur_wb_addr = hold_q ? sv_wb_addr : in_wb_addr;

    assign is_div = cur_op inside {exec_pkg::ALU_DIV, exec_pkg::ALU_DIVU,
                                   exec_pkg::ALU_REM, exec_pkg::ALU_REMU};
    assign is_rem = cur_op inside {exec_pkg::ALU_REM, exec_pkg::ALU_REMU};

    assign dv.start     = (state_q == exec_pkg::DIV_IDLE) && is_div && !dv.busy && !flush;
    assign dv.abort     = flush;
    assign dv.is_signed = cur_op inside {exec_pkg::ALU_DIV, exec_pkg::ALU_REM};
    assign dv.dividend  = cur_op1;
    assign dv.divisor   = cur_op2;

    assign div_pick  = is_rem ? dv.remainder : dv.quotient;
    assign div_ready = (state_q == exec_pkg::DIV_DONE) ||
                       (state_q == exec_pkg::DIV_BUSY && dv.valid);

    assign ex_stall = is_div && !div_ready;
    assign result   = !is_div ? alu_result :
                      (state_q == exec_pkg::DIV_DONE) ? saved_q : div_pick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= exec_pkg::DIV_IDLE;
        end else if (flush) begin
            state_q <= exec_pkg::DIV_IDLE;
        end else begin
            case (state_q)
                exec_pkg::DIV_IDLE: if (dv.start) state_q <= exec_pkg::DIV_BUSY;
                exec_pkg::DIV_BUSY: begin
                    // memory stage stalled, park the result
                    if (dv.valid) begin
                        state_q <= mem_stall ? exec_pkg::DIV_DONE : exec_pkg::DIV_IDLE;
                    end
                end
                exec_pkg::DIV_DONE: if (!mem_stall) state_q <= exec_pkg::DIV_IDLE;
                default:            state_q <= exec_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == exec_pkg::DIV_BUSY && dv.valid) begin
            saved_q <= div_pick;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q    <= 1'b0;
            sv_op     <= exec_pkg::ALU_X;
            sv_rf_wen <= 1'b0;
        end else if (flush) begin
            hold_q    <= 1'b0;
            sv_op     <= exec_pkg::ALU_X;
            sv_rf_wen <= 1'b0;
        end else begin
            hold_q    <= ex_stall || mem_stall;
            sv_op     <= cur_op;
            sv_rf_wen <= cur_rf_wen;
        end
    end

    always_ff @(posedge clk) begin
        sv_op1     <= cur_op1;
        sv_op2     <= cur_op2;
        sv_pc      <= cur_pc;
        sv_imm_b   <= cur_imm_b;
        sv_rs2     <= cur_rs2;
        sv_wb_addr <= cur_wb_addr;
    end

    // a stall always has divider work behind it
    a_stall_has_divide: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_stall && !flush) |-> (dv.start || dv.busy))
        else $error("ex_stall raised with the divider idle");

    // divider must accept every start we issue
    a_start_taken: assert property (@(posedge clk) disable iff (!rst_n)
        dv.start |=> dv.busy)
        else $error("divider did not take the start");

endmodule

`default_nettype wire

/* hw/exec_pipe_reg.sv */
`default_nettype none
`include "exec_config.svh"

module exec_pipe_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  mem_stall,
    input  logic                  ex_stall,
    input  logic [`EXEC_XLEN-1:0] result,
    input  logic                  br_taken,
    input  logic [`EXEC_XLEN-1:0] br_target,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] rs2,
    input  logic                  rf_wen,
    input  logic [4:0]            wb_addr,
    output logic [`EXEC_XLEN-1:0] alu_out,
    output logic                  out_br_taken,
    output logic [`EXEC_XLEN-1:0] out_br_target,
    output logic [`EXEC_XLEN-1:0] out_pc,
    output logic [`EXEC_XLEN-1:0] out_rs2,
    output logic                  out_rf_wen,
    output logic [4:0]            out_wb_addr
);

    logic bubble;
    logic load;

    // flush wins over the memory stall
    assign bubble = flush || (ex_stall && !mem_stall);
    assign load   = !mem_stall || flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_pc       <= `EXEC_PC_NOP;
            out_rf_wen   <= 1'b0;
            out_br_taken <= 1'b0;
        end else if (bubble) begin
            out_pc       <= `EXEC_PC_NOP;
            out_rf_wen   <= 1'b0;
            out_br_taken <= 1'b0;
        end else if (load) begin
            out_pc       <= pc;
            out_rf_wen   <= rf_wen;
            out_br_taken <= br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            alu_out       <= result;
            out_br_target <= br_target;
            out_rs2       <= rs2;
            out_wb_addr   <= wb_addr;
        end
    end

    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_rf_wen && !out_br_taken && out_pc == `EXEC_PC_NOP)
        else $error("flush did not produce a bubble");

endmodule

`default_nettype wire

/* hw/exec_divider.sv */
`default_nettype none
`include "exec_config.svh"

module exec_divider (
    input logic clk,
    input logic rst_n,
    div_if.div  dv
);

    localparam int W     = `EXEC_XLEN;
    localparam int STEPS = `EXEC_DIV_STEPS;
    localparam int CW    = $clog2(STEPS + 1);

    logic          busy_q;
    logic          valid_q;
    logic [CW-1:0] cnt_q;
    logic [W-1:0]  rem_q;
    logic [W-1:0]  quo_q;
    logic [W-1:0]  dvs_q;
    logic          neg_quo_q;
    logic          neg_rem_q;
    logic          zero_q;
    logic [W-1:0]  quotient_q;
    logic [W-1:0]  remainder_q;

    logic          a_neg;
    logic          b_neg;
    logic [W-1:0]  a_mag;
    logic [W-1:0]  b_mag;
    logic [W:0]    rem_shift;
    logic [W:0]    diff;
    logic          last;

    assign a_neg = dv.is_signed && dv.dividend[W-1];
    assign b_neg = dv.is_signed && dv.divisor[W-1];
    assign a_mag = a_neg ? -dv.dividend : dv.dividend;
    assign b_mag = b_neg ? -dv.divisor : dv.divisor;

    assign rem_shift = {rem_q, quo_q[W-1]};
    assign diff      = rem_shift - {1'b0, dvs_q};
    assign last      = cnt_q == CW'(STEPS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            valid_q <= 1'b0;
            if (dv.abort) begin
                busy_q <= 1'b0;
                cnt_q  <= '0;
            end else if (dv.start && !busy_q) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                if (last) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    // restoring step, quotient bits shift in at the bottom
    always_ff @(posedge clk) begin
        if (dv.start && !busy_q) begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            dvs_q     <= b_mag;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            zero_q    <= dv.divisor == '0;
        end else if (busy_q && !last) begin
            if (!diff[W]) begin
                rem_q <= diff[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end else if (busy_q) begin
            // overflow case falls out of the sign fix as dividend, remainder 0
            quotient_q  <= zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
            // divide by zero leaves the dividend here already
            remainder_q <= neg_rem_q ? -rem_q : rem_q;
        end
    end

    assign dv.busy      = busy_q;
    assign dv.valid     = valid_q;
    assign dv.quotient  = quotient_q;
    assign dv.remainder = remainder_q;

    a_no_valid_after_abort: assert property (@(posedge clk) disable iff (!rst_n)
        dv.abort |=> !dv.valid && !dv.busy)
        else $error("divider result after abort");

endmodule

`default_nettype wire

/* hw/exec_alu.sv */
`default_nettype none
`include "exec_config.svh"

module exec_alu (
    input  exec_pkg::alu_op_e     op,
    input  logic [`EXEC_XLEN-1:0] op1,
    input  logic [`EXEC_XLEN-1:0] op2,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] imm_b,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  br_taken,
    output logic [`EXEC_XLEN-1:0] br_target
);

    logic [4:0]            shamt;
    logic                  lt_s;
    logic                  lt_u;
    logic                  eq;
    logic [`EXEC_XLEN-1:0] sum;

    assign shamt = op2[4:0];
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;
    assign eq    = op1 == op2;
    assign sum   = op1 + op2;

    always_comb begin
        case (op)
            exec_pkg::ALU_ADD:   result = sum;
            exec_pkg::ALU_SUB:   result = op1 - op2;
            exec_pkg::ALU_AND:   result = op1 & op2;
            exec_pkg::ALU_OR:    result = op1 | op2;
            exec_pkg::ALU_XOR:   result = op1 ^ op2;
            exec_pkg::ALU_SLL:   result = op1 << shamt;
            exec_pkg::ALU_SRL:   result = op1 >> shamt;
            exec_pkg::ALU_SRA:   result = $unsigned($signed(op1) >>> shamt);
            exec_pkg::ALU_SLT:   result = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
            exec_pkg::ALU_SLTU:  result = {{(`EXEC_XLEN-1){1'b0}}, lt_u};
            exec_pkg::ALU_JALR:  result = {sum[`EXEC_XLEN-1:1], 1'b0};
            exec_pkg::ALU_COPY1: result = op1;
            default:             result = '0;
        endcase
    end

    always_comb begin
        case (op)
            exec_pkg::BR_BEQ:  br_taken = eq;
            exec_pkg::BR_BNE:  br_taken = !eq;
            exec_pkg::BR_BLT:  br_taken = lt_s;
            exec_pkg::BR_BGE:  br_taken = !lt_s;
            exec_pkg::BR_BLTU: br_taken = lt_u;
            exec_pkg::BR_BGEU: br_taken = !lt_u;
            default:           br_taken = 1'b0;
        endcase
    end

    assign br_target = pc + imm_b;

endmodule

`default_nettype wire

/* hw/div_if.sv */
`default_nettype none
`include "exec_config.svh"

interface div_if;
    logic                  start;
    logic                  abort;
    logic                  is_signed;
    logic [`EXEC_XLEN-1:0] dividend;
    logic [`EXEC_XLEN-1:0] divisor;
    logic                  busy;
    logic                  valid;
    logic [`EXEC_XLEN-1:0] quotient;
    logic [`EXEC_XLEN-1:0] remainder;

    modport ctrl (
        output start, abort, is_signed, dividend, divisor,
        input  busy, valid, quotient, remainder
    );

    modport div (
        input  start, abort, is_signed, dividend, divisor,
        output busy, valid, quotient, remainder
    );
endinterface

`default_nettype wire

/* hw/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    typedef enum logic [4:0] {
        ALU_X,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_JALR,
        ALU_COPY1,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU
    } alu_op_e;

    // divide sequencing in the control block
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

endpackage

`default_nettype wire

/* include/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath width
`define EXEC_XLEN 32

// one quotient bit per iteration
`define EXEC_DIV_STEPS `EXEC_XLEN

// pc carried by a bubble
`define EXEC_PC_NOP {`EXEC_XLEN{1'b1}}

`endif
